/* common/mips_exec_params.svh */
`ifndef MIPS_EXEC_PARAMS_SVH
`define MIPS_EXEC_PARAMS_SVH

// Operand width, one machine word
`define MIPS_DATA_WIDTH 32

// One multiply or divide iteration per operand bit
`define MIPS_MULDIV_STEPS 32

`endif

/* common/mips_exec_pkg.sv */
`default_nettype none

package mips_exec_pkg;

  typedef enum logic [1:0] {
    MD_MULT  = 2'd0,
    MD_MULTU = 2'd1,
    MD_DIV   = 2'd2,
    MD_DIVU  = 2'd3
  } muldiv_op_e;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    RUN    = 2'd1,
    FINISH = 2'd2
  } muldiv_state_e;

endpackage

`default_nettype wire

/* common/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

  typedef enum logic [5:0] {
    OP_RTYPE  = 6'h00,
    OP_REGIMM = 6'h01,
    OP_BEQ    = 6'h04,
    OP_BNE    = 6'h05,
    OP_BLEZ   = 6'h06,
    OP_BGTZ   = 6'h07,
    OP_ADDIU  = 6'h09,
    OP_SLTI   = 6'h0a,
    OP_SLTIU  = 6'h0b,
    OP_ANDI   = 6'h0c,
    OP_ORI    = 6'h0d,
    OP_XORI   = 6'h0e,
    OP_LUI    = 6'h0f,
    OP_LB     = 6'h20,
    OP_LH     = 6'h21,
    OP_LWL    = 6'h22,
    OP_LW     = 6'h23,
    OP_LBU    = 6'h24,
    OP_LHU    = 6'h25,
    OP_LWR    = 6'h26,
    OP_SB     = 6'h28,
    OP_SH     = 6'h29,
    OP_SW     = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    F_SLL   = 6'h00,
    F_SRL   = 6'h02,
    F_SRA   = 6'h03,
    F_SLLV  = 6'h04,
    F_SRLV  = 6'h06,
    F_SRAV  = 6'h07,
    F_MFHI  = 6'h10,
    F_MTHI  = 6'h11,
    F_MFLO  = 6'h12,
    F_MTLO  = 6'h13,
    F_MULT  = 6'h18,
    F_MULTU = 6'h19,
    F_DIV   = 6'h1a,
    F_DIVU  = 6'h1b,
    F_ADDU  = 6'h21,
    F_SUBU  = 6'h23,
    F_AND   = 6'h24,
    F_OR    = 6'h25,
    F_XOR   = 6'h26,
    F_NOR   = 6'h27,
    F_SLT   = 6'h2a,
    F_SLTU  = 6'h2b
  } funct_e;

  // Selector in the rt field of opcode 1
  typedef enum logic [4:0] {
    RI_BLTZ   = 5'h00,
    RI_BGEZ   = 5'h01,
    RI_BLTZAL = 5'h10,
    RI_BGEZAL = 5'h11
  } regimm_e;

  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    funct_e     funct;
  } r_form_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_form_t;

  // Same 32-bit word, decoded as R or I format
  typedef union packed {
    r_form_t rform;
    i_form_t iform;
  } instr_u;

endpackage

`default_nettype wire

/* design/alu_unit.sv */
`default_nettype none

`include "mips_exec_params.svh"

module alu_unit (
  input  mips_isa_pkg::instr_u            instr,
  input  logic [`MIPS_DATA_WIDTH-1:0]     rs_value,
  input  logic [`MIPS_DATA_WIDTH-1:0]     rt_value,
  input  logic [`MIPS_DATA_WIDTH-1:0]     hi,
  input  logic [`MIPS_DATA_WIDTH-1:0]     lo,
  output logic [`MIPS_DATA_WIDTH-1:0]     result,
  output logic                            branch_taken,
  output logic                            muldiv_start_req,
  output mips_exec_pkg::muldiv_op_e       muldiv_op,
  output logic                            mthi_req,
  output logic                            mtlo_req
);
  import mips_isa_pkg::*;
  import mips_exec_pkg::*;

  localparam int w = `MIPS_DATA_WIDTH;

  logic signed [w-1:0] rs_s;
  logic signed [w-1:0] rt_s;
  logic [w-1:0]        sign_ext;
  logic [w-1:0]        zero_ext;
  logic [w-1:0]        diff;

  assign rs_s     = rs_value;
  assign rt_s     = rt_value;
  assign sign_ext = {{(w-16){instr.iform.imm[15]}}, instr.iform.imm};
  assign zero_ext = {{(w-16){1'b0}}, instr.iform.imm};
  assign diff     = rs_value - rt_value; // Shared by BEQ and BNE

  always_comb
  begin
    result           = '0;
    branch_taken     = 1'b0;
    muldiv_start_req = 1'b0;
    muldiv_op        = MD_MULT;
    mthi_req         = 1'b0;
    mtlo_req         = 1'b0;
    if (instr.rform.opcode == OP_RTYPE)
    begin
      case (instr.rform.funct)
        F_SLL:  result = rt_value << instr.rform.shamt;
        F_SRL:  result = rt_value >> instr.rform.shamt;
        F_SRA:  result = rt_s >>> instr.rform.shamt; // Sign bit fills from the left
        F_SLLV: result = rt_value << rs_value[4:0];
        F_SRLV: result = rt_value >> rs_value[4:0];
        F_SRAV: result = rt_s >>> rs_value[4:0];
        F_ADDU: result = rs_value + rt_value;
        F_SUBU: result = rs_value - rt_value;
        F_AND:  result = rs_value & rt_value;
        F_OR:   result = rs_value | rt_value;
        F_XOR:  result = rs_value ^ rt_value;
        F_NOR:  result = ~(rs_value | rt_value);
        F_SLT:  result = {{(w-1){1'b0}}, (rs_s < rt_s)};
        F_SLTU: result = {{(w-1){1'b0}}, (rs_value < rt_value)};
        F_MFHI: result = hi;
        F_MFLO: result = lo;
        F_MTHI: mthi_req = 1'b1;
        F_MTLO: mtlo_req = 1'b1;
        F_MULT, F_MULTU, F_DIV, F_DIVU:
        begin
          muldiv_start_req = 1'b1;
          muldiv_op        = muldiv_op_e'(instr.rform.funct[1:0]); // Low funct bits pick the op
        end
        default: result = '0;
      endcase
    end
    else
    begin
      case (instr.iform.opcode)
        OP_ADDIU: result = rs_value + sign_ext;
        OP_ANDI:  result = rs_value & zero_ext;
        OP_ORI:   result = rs_value | zero_ext;
        OP_XORI:  result = rs_value ^ zero_ext;
        OP_LUI:   result = {instr.iform.imm, {(w-16){1'b0}}};
        OP_SLTI:  result = {{(w-1){1'b0}}, (rs_s < $signed(sign_ext))};
        OP_SLTIU: result = {{(w-1){1'b0}}, (rs_value < sign_ext)};
        OP_BEQ:
        begin
          result       = diff;
          branch_taken = (diff == '0);
        end
        OP_BNE:   branch_taken = (diff != '0); // Result stays zero
        OP_REGIMM:
        begin
          case (instr.iform.rt)
            RI_BLTZ, RI_BLTZAL: branch_taken = (rs_s < 0);
            RI_BGEZ, RI_BGEZAL: branch_taken = (rs_s >= 0);
            default:            branch_taken = 1'b0;
          endcase
        end
        OP_BGTZ:  branch_taken = (instr.iform.rt == 5'd0) && (rs_s > 0);
        OP_BLEZ:  branch_taken = (instr.iform.rt == 5'd0) && (rs_s <= 0);
        OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR, OP_SB, OP_SH, OP_SW:
          result = rs_value + sign_ext; // Effective address
        default:  result = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* muldiv/muldiv_ctrl.sv */
`default_nettype none

`include "mips_exec_params.svh"

module muldiv_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  mips_exec_pkg::muldiv_op_e op,
  input  logic                      last_step,
  output logic                      load,
  output logic                      step,
  output logic                      finish,
  output logic                      busy,
  output logic                      done,
  output mips_exec_pkg::muldiv_op_e op_latched
);
  import mips_exec_pkg::*;

  muldiv_state_e state_q;
  muldiv_op_e    op_q;

  assign load   = start;
  assign step   = (state_q == RUN);
  assign finish = (state_q == FINISH);
  assign busy   = (state_q != IDLE);

  // Live op on the load edge, held op afterwards
  assign op_latched = load ? op : op_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      done    <= 1'b0;
    end
    else
    begin
      done <= (state_q == FINISH); // One cycle after FINISH
      case (state_q)
        IDLE:    if (start) state_q <= RUN;
        RUN:     if (last_step) state_q <= FINISH;
        FINISH:  state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
      op_q <= op;
  end

  a_no_start_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !(start && busy));

  // Issue to done is a fixed latency
  a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> ##(`MIPS_MULDIV_STEPS + 2) done);

endmodule

`default_nettype wire

/* muldiv/muldiv_counter.sv */
`default_nettype none

`include "mips_exec_params.svh"

module muldiv_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic clear,
  input  logic advance,
  output logic last_step
);

  localparam int cnt_w = $clog2(`MIPS_MULDIV_STEPS + 1);

  logic [cnt_w-1:0] count_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n || clear)
      count_q <= '0;
    else if (advance)
      count_q <= count_q + 1'b1;
  end

  assign last_step = (count_q == cnt_w'(`MIPS_MULDIV_STEPS - 1)); // Final iteration in flight

  a_within_limit: assert property (@(posedge clk) disable iff (!rst_n)
    advance |-> (count_q < cnt_w'(`MIPS_MULDIV_STEPS)));

endmodule

`default_nettype wire

/* muldiv/muldiv_datapath.sv */
`default_nettype none

`include "mips_exec_params.svh"

module muldiv_datapath (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load,
  input  logic                          step,
  input  logic                          finish,
  input  mips_exec_pkg::muldiv_op_e     op,
  input  logic [`MIPS_DATA_WIDTH-1:0]   rs_value,
  input  logic [`MIPS_DATA_WIDTH-1:0]   rt_value,
  input  logic                          mthi,
  input  logic                          mtlo,
  output logic [`MIPS_DATA_WIDTH-1:0]   hi,
  output logic [`MIPS_DATA_WIDTH-1:0]   lo
);
  import mips_exec_pkg::*;

  localparam int w = `MIPS_DATA_WIDTH;

  logic         is_div;
  logic         is_signed;
  logic         rs_neg;
  logic         rt_neg;
  logic         div_zero;
  logic [w-1:0] rs_mag;
  logic [w-1:0] rt_mag;

  logic [w-1:0] acc_q; // Upper product half or partial remainder
  logic [w-1:0] quo_q; // Multiplier bits or quotient
  logic [w-1:0] opb_q; // Multiplicand or divisor
  logic         neg_prod_q;
  logic         neg_rem_q;

  logic [w:0]     mul_sum;
  logic [w:0]     div_shift;
  logic [w:0]     div_diff;
  logic           div_fits;
  logic [2*w-1:0] product;
  logic [2*w-1:0] prod_fixed;
  logic [w-1:0]   quo_fixed;
  logic [w-1:0]   rem_fixed;

  assign is_div    = (op == MD_DIV) || (op == MD_DIVU);
  assign is_signed = (op == MD_MULT) || (op == MD_DIV);
  assign rs_neg    = is_signed & rs_value[w-1];
  assign rt_neg    = is_signed & rt_value[w-1];
  assign div_zero  = is_div & (rt_value == '0);

  // Zero divisor keeps rs raw so it lands in HI untouched
  assign rs_mag = (rs_neg && !div_zero) ? -rs_value : rs_value;
  assign rt_mag = rt_neg ? -rt_value : rt_value;

  assign mul_sum   = {1'b0, acc_q} + (quo_q[0] ? {1'b0, opb_q} : '0);
  assign div_shift = {acc_q, quo_q[w-1]};
  assign div_fits  = (div_shift >= {1'b0, opb_q});
  assign div_diff  = div_shift - {1'b0, opb_q};

  assign product    = {acc_q, quo_q};
  assign prod_fixed = neg_prod_q ? -product : product;
  assign quo_fixed  = neg_prod_q ? -quo_q : quo_q;
  assign rem_fixed  = neg_rem_q ? -acc_q : acc_q; // Remainder takes the dividend sign

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      acc_q      <= '0;
      quo_q      <= rs_mag;
      opb_q      <= rt_mag;
      neg_prod_q <= (rs_neg ^ rt_neg) & ~div_zero;
      neg_rem_q  <= rs_neg & ~div_zero;
    end
    else if (step)
    begin
      if (is_div)
      begin
        acc_q <= div_fits ? div_diff[w-1:0] : div_shift[w-1:0]; // Restore on failed trial
        quo_q <= {quo_q[w-2:0], div_fits};
      end
      else
      begin
        acc_q <= mul_sum[w:1];
        quo_q <= {mul_sum[0], quo_q[w-1:1]};
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      hi <= '0;
      lo <= '0;
    end
    else if (finish)
    begin
      if (is_div)
      begin
        hi <= rem_fixed;
        lo <= quo_fixed;
      end
      else
        {hi, lo} <= prod_fixed;
    end
    else
    begin
      if (mthi)
        hi <= rs_value;
      if (mtlo)
        lo <= rs_value;
    end
  end

endmodule

`default_nettype wire

/* design/mips_execute.sv */
`default_nettype none

`include "mips_exec_params.svh"

module mips_execute (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        instr_valid,
  input  mips_isa_pkg::instr_u        instr,
  input  logic [`MIPS_DATA_WIDTH-1:0] rs_value,
  input  logic [`MIPS_DATA_WIDTH-1:0] rt_value,
  output logic                        result_valid,
  output logic [`MIPS_DATA_WIDTH-1:0] alu_result,
  output logic                        branch_taken,
  output logic [`MIPS_DATA_WIDTH-1:0] hi,
  output logic [`MIPS_DATA_WIDTH-1:0] lo,
  output logic                        muldiv_busy,
  output logic                        muldiv_done
);
  import mips_exec_pkg::*;

  logic [`MIPS_DATA_WIDTH-1:0] alu_res;
  logic                        alu_branch;
  logic                        start_req;
  logic                        mthi_req;
  logic                        mtlo_req;
  muldiv_op_e                  req_op;
  muldiv_op_e                  md_op;
  logic                        md_start;
  logic                        md_load;
  logic                        md_step;
  logic                        md_finish;
  logic                        last_step;

  assign md_start = instr_valid & start_req; // Decode flags count only on issue

  alu_unit u_alu (
    .instr            (instr),
    .rs_value         (rs_value),
    .rt_value         (rt_value),
    .hi               (hi),
    .lo               (lo),
    .result           (alu_res),
    .branch_taken     (alu_branch),
    .muldiv_start_req (start_req),
    .muldiv_op        (req_op),
    .mthi_req         (mthi_req),
    .mtlo_req         (mtlo_req)
  );

  muldiv_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (md_start),
    .op         (req_op),
    .last_step  (last_step),
    .load       (md_load),
    .step       (md_step),
    .finish     (md_finish),
    .busy       (muldiv_busy),
    .done       (muldiv_done),
    .op_latched (md_op)
  );

  muldiv_counter u_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (md_load),
    .advance   (md_step),
    .last_step (last_step)
  );

  muldiv_datapath u_datapath (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (md_load),
    .step     (md_step),
    .finish   (md_finish),
    .op       (md_op),
    .rs_value (rs_value),
    .rt_value (rt_value),
    .mthi     (instr_valid & mthi_req),
    .mtlo     (instr_valid & mtlo_req),
    .hi       (hi),
    .lo       (lo)
  );

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      result_valid <= 1'b0;
      branch_taken <= 1'b0;
    end
    else
    begin
      result_valid <= instr_valid; // Fixed one-cycle latency
      if (instr_valid)
        branch_taken <= alu_branch;
    end
  end

  always_ff @(posedge clk)
  begin
    if (instr_valid)
      alu_result <= alu_res;
  end

  // HI and LO belong to the running operation until done
  a_no_move_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid && (mthi_req || mtlo_req) |-> !muldiv_busy);

endmodule

`default_nettype wire

/* sim/tb_mips_execute.sv */
`default_nettype none

`include "mips_exec_params.svh"

module tb_mips_execute;
  import mips_isa_pkg::*;
  import mips_exec_pkg::*;

  localparam int w       = `MIPS_DATA_WIDTH;
  localparam int max_vec = 64;
  localparam int name_w  = 8 * 24;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         instr_valid;
  instr_u       instr;
  logic [w-1:0] rs_value;
  logic [w-1:0] rt_value;
  logic         result_valid;
  logic [w-1:0] alu_result;
  logic         branch_taken;
  logic [w-1:0] hi;
  logic [w-1:0] lo;
  logic         muldiv_busy;
  logic         muldiv_done;

  // Vectors from the golden file
  logic [name_w-1:0] vec_name [0:max_vec-1];
  logic [63:0]       vec_kind [0:max_vec-1];
  logic [w-1:0]      vec_instr [0:max_vec-1];
  logic [w-1:0]      vec_rs [0:max_vec-1];
  logic [w-1:0]      vec_rt [0:max_vec-1];
  logic [w-1:0]      vec_result [0:max_vec-1];
  logic [w-1:0]      vec_branch [0:max_vec-1];
  logic [w-1:0]      vec_hi [0:max_vec-1];
  logic [w-1:0]      vec_lo [0:max_vec-1];

  logic [name_w-1:0] tok;
  logic [63:0]       kind;
  logic [w-1:0]      f_instr;
  logic [w-1:0]      f_rs;
  logic [w-1:0]      f_rt;
  logic [w-1:0]      f_result;
  logic [w-1:0]      f_branch;
  logic [w-1:0]      f_hi;
  logic [w-1:0]      f_lo;
  logic [8*128-1:0]  skip_line;

  int            fd;
  int            code;
  int            num_vec;
  int            cycle = 0;
  int            cycle_limit = 0;
  int            test_errs;
  int            pass_count;
  int            fail_count;
  muldiv_state_e ctrl_state;

  mips_execute UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .rs_value     (rs_value),
    .rt_value     (rt_value),
    .result_valid (result_valid),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .hi           (hi),
    .lo           (lo),
    .muldiv_busy  (muldiv_busy),
    .muldiv_done  (muldiv_done)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle_limit > 0 && cycle >= cycle_limit)
    begin
      ctrl_state = UUT.u_ctrl.state_q;
      $display("Timeout after %0d cycles, multiply/divide unit in state %s",
               cycle, ctrl_state.name());
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input string field,
                             input logic [w-1:0] expected, input logic [w-1:0] actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %0s %0s: expected %h, actual %h", name, field, expected, actual);
      test_errs++;
    end
  endtask

  task automatic report_test(input string name);
    if (test_errs == 0)
    begin
      pass_count++;
      $display("PASS %0s", name);
    end
    else
    begin
      fail_count++;
      $display("FAIL %0s with %0d mismatches", name, test_errs);
    end
  endtask

  // Drives a one-cycle strobe and returns one cycle after the issue edge
  task automatic issue(input int idx, output int issued_at);
    @(posedge clk);
    #1;
    issued_at   = cycle;
    instr_valid = 1'b1;
    instr       = vec_instr[idx];
    rs_value    = vec_rs[idx];
    rt_value    = vec_rt[idx];
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
  endtask

  task automatic run_alu(input int idx);
    string name;
    int    issued_at;
    name = $sformatf("%0s", vec_name[idx]);
    issue(idx, issued_at);
    check_value(name, "result_valid", w'(1), {{(w-1){1'b0}}, result_valid});
    check_value(name, "result", vec_result[idx], alu_result);
    check_value(name, "branch", vec_branch[idx], {{(w-1){1'b0}}, branch_taken});
    check_value(name, "hi", vec_hi[idx], hi);
    check_value(name, "lo", vec_lo[idx], lo);
  endtask

  task automatic run_muldiv(input int idx);
    string name;
    int    issued_at;
    int    saved_errs;
    name = $sformatf("%0s", vec_name[idx]);
    issue(idx, issued_at);
    check_value(name, "result_valid", w'(1), {{(w-1){1'b0}}, result_valid});
    check_value(name, "result", vec_result[idx], alu_result);
    check_value(name, "branch", vec_branch[idx], {{(w-1){1'b0}}, branch_taken});
    check_value(name, "busy", w'(1), {{(w-1){1'b0}}, muldiv_busy});
    if (idx + 1 < num_vec && vec_kind[idx + 1] == 64'("overlap"))
    begin
      saved_errs = test_errs; // ALU op slotted in while busy
      test_errs  = 0;
      run_alu(idx + 1);
      report_test($sformatf("%0s", vec_name[idx + 1]));
      test_errs  = saved_errs;
    end
    while (!muldiv_done)
    begin
      @(posedge clk);
      #1;
    end
    check_value(name, "done_latency", w'(`MIPS_MULDIV_STEPS + 2), w'(cycle - issued_at));
    check_value(name, "busy_at_done", '0, {{(w-1){1'b0}}, muldiv_busy});
    check_value(name, "hi", vec_hi[idx], hi);
    check_value(name, "lo", vec_lo[idx], lo);
  endtask

  initial
  begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    rs_value    = '0;
    rt_value    = '0;
    pass_count  = 0;
    fail_count  = 0;
    num_vec     = 0;

    fd = $fopen("sim/mips_execute_golden.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the golden file sim/mips_execute_golden.txt");
      fail_count++;
    end
    else
    begin
      while (!$feof(fd) && num_vec < max_vec)
      begin
        code = $fscanf(fd, "%s", tok);
        if (code == 1)
        begin
          if (tok == name_w'("#"))
            code = $fgets(skip_line, fd); // Column notes
          else
          begin
            code = $fscanf(fd, "%s %h %h %h %h %h %h %h", kind, f_instr, f_rs, f_rt,
                           f_result, f_branch, f_hi, f_lo);
            if (code != 8)
            begin
              $display("Golden line for %0s is malformed", tok);
              fail_count++;
            end
            vec_name[num_vec]   = tok;
            vec_kind[num_vec]   = kind;
            vec_instr[num_vec]  = f_instr;
            vec_rs[num_vec]     = f_rs;
            vec_rt[num_vec]     = f_rt;
            vec_result[num_vec] = f_result;
            vec_branch[num_vec] = f_branch;
            vec_hi[num_vec]     = f_hi;
            vec_lo[num_vec]     = f_lo;
            num_vec++;
          end
        end
      end
      $fclose(fd);
    end
    if (num_vec == 0)
    begin
      $display("The golden file holds no vectors");
      fail_count++;
    end
    cycle_limit = num_vec * 40 + 100;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_errs = 0;
    check_value("reset_state", "result_valid", '0, {{(w-1){1'b0}}, result_valid});
    check_value("reset_state", "muldiv_busy", '0, {{(w-1){1'b0}}, muldiv_busy});
    check_value("reset_state", "branch", '0, {{(w-1){1'b0}}, branch_taken});
    check_value("reset_state", "hi", '0, hi);
    check_value("reset_state", "lo", '0, lo);
    report_test("reset_state");

    for (int i = 0; i < num_vec; i++)
    begin
      test_errs = 0;
      if (vec_kind[i] == 64'("alu"))
      begin
        run_alu(i);
        report_test($sformatf("%0s", vec_name[i]));
      end
      else if (vec_kind[i] == 64'("muldiv"))
      begin
        run_muldiv(i);
        report_test($sformatf("%0s", vec_name[i]));
      end
      else if (vec_kind[i] != 64'("overlap")) // Overlap lines run inside run_muldiv
      begin
        $display("Unknown vector kind for %0s in the golden file", vec_name[i]);
        fail_count++;
      end
    end

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* mips_execute.f */
+incdir+common
common/mips_exec_pkg.sv
common/mips_isa_pkg.sv
design/alu_unit.sv
muldiv/muldiv_ctrl.sv
muldiv/muldiv_counter.sv
muldiv/muldiv_datapath.sv
design/mips_execute.sv
sim/tb_mips_execute.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --assert --top-module tb_mips_execute -f mips_execute.f \
  -o tb_mips_execute > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_mips_execute > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1

/* sim/mips_execute_golden.txt */
# name kind instr rs rt | expected result branch hi lo, all values in hex
# alu checks one cycle after issue, muldiv waits for done, overlap runs during the muldiv before
addu_wrap alu 00221821 7fffffff 00000001 80000000 0 00000000 00000000
subu_neg alu 00221823 00000005 00000007 fffffffe 0 00000000 00000000
and_mask alu 00221824 f0f0ff00 ff00f0f0 f000f000 0 00000000 00000000
xor_mix alu 00221826 aaaa5555 ffff0000 55555555 0 00000000 00000000
nor_mix alu 00221827 0f0f0f0f 00ff00ff f000f000 0 00000000 00000000
sll_4 alu 00221900 00000000 80000001 00000010 0 00000000 00000000
srl_8 alu 00221a02 00000000 80000000 00800000 0 00000000 00000000
sra_8 alu 00221a03 00000000 80000000 ff800000 0 00000000 00000000
srav_rs alu 00221807 00000024 f0000000 ff000000 0 00000000 00000000
slt_neg alu 0022182a ffffffff 00000001 00000001 0 00000000 00000000
sltu_big alu 0022182b ffffffff 00000001 00000000 0 00000000 00000000
addiu_neg alu 2422ffff 00000010 00000000 0000000f 0 00000000 00000000
slti_neg alu 28228000 ffff0000 00000000 00000001 0 00000000 00000000
sltiu_ext alu 2c228000 7fffffff 00000000 00000001 0 00000000 00000000
andi_zext alu 3022ff00 12345678 00000000 00005600 0 00000000 00000000
lui_imm alu 3c02beef 00000000 00000000 beef0000 0 00000000 00000000
lw_addr alu 8c22fffc 00001000 00000000 00000ffc 0 00000000 00000000
sw_addr alu ac220010 00001000 00000000 00001010 0 00000000 00000000
beq_taken alu 10220004 00000005 00000005 00000000 1 00000000 00000000
bne_taken alu 14220004 00000005 00000007 00000000 1 00000000 00000000
bne_not_taken alu 14220004 00000005 00000005 00000000 0 00000000 00000000
bltz_neg alu 04200004 80000000 00000000 00000000 1 00000000 00000000
bgez_zero alu 04210004 00000000 00000000 00000000 1 00000000 00000000
bltzal_pos alu 04300004 00000005 00000000 00000000 0 00000000 00000000
bgezal_neg alu 04310004 ffffffff 00000000 00000000 0 00000000 00000000
bgtz_pos alu 1c200004 00000001 00000000 00000000 1 00000000 00000000
bgtz_zero alu 1c200004 00000000 00000000 00000000 0 00000000 00000000
blez_neg alu 18200004 ffffffff 00000000 00000000 1 00000000 00000000
blez_pos alu 18200004 00000002 00000000 00000000 0 00000000 00000000
mult_min_min muldiv 00220018 80000000 80000000 00000000 0 40000000 00000000
mult_neg_max muldiv 00220018 ffffffff 7fffffff 00000000 0 ffffffff 80000001
multu_max muldiv 00220019 ffffffff ffffffff 00000000 0 fffffffe 00000001
alu_during_mult overlap 00221821 00000003 00000004 00000007 0 ffffffff 80000001
div_neg_pos muldiv 0022001a fffffff9 00000002 00000000 0 ffffffff fffffffd
div_pos_neg muldiv 0022001a 00000007 fffffffe 00000000 0 00000001 fffffffd
divu_max muldiv 0022001b ffffffff 00000010 00000000 0 0000000f 0fffffff
div_by_zero muldiv 0022001a 80000005 00000000 00000000 0 80000005 ffffffff
divu_by_zero muldiv 0022001b 00001234 00000000 00000000 0 00001234 ffffffff
mthi_write alu 00200011 deadbeef 00000000 00000000 0 deadbeef ffffffff
mtlo_write alu 00200013 cafef00d 00000000 00000000 0 deadbeef cafef00d
mfhi_read alu 00001810 00000000 00000000 deadbeef 0 deadbeef cafef00d
mflo_read alu 00001812 00000000 00000000 cafef00d 0 deadbeef cafef00d
